//--- Bender.yml
package:
  name: fabric_target

sources:
  - logic/fabricPkg.sv
  - logic/wbTargetIf.sv
  - logic/wbApertureRouter.sv
  - logic/fabricRegisters.sv
  - logic/reservedIdRegs.sv
  - logic/accessTimeout.sv
  - logic/fabricTop.sv

  - target: test
    include_dirs:
      - bench
    files:
      - bench/fabricTb.sv

//--- bench/wbHostTasks.svh
// Host side bus tasks for the fabric target testbench
// Single transfers with a bounded wait for ack, plus value checks
// that count mismatches

`ifndef WB_HOST_TASKS_SVH
`define WB_HOST_TASKS_SVH

// Byte address from aperture number and word index
function automatic logic [BUS_ADR_W-1:0] byteAddress(input int aperture, input regIdx_t idx);
    byteAddress = {aperture[3:0], 4'b0000, idx, 2'b00};
endfunction

// One transfer, held until ack is seen, then strobe dropped
task automatic busAccess(input logic [BUS_ADR_W-1:0] adr, input logic we,
                         input byteStb_t stb, input busData_t wrDat,
                         output busData_t rdDat, output int latency);
    int waited;
    bit gotAck;
    waited = 0;
    gotAck = 1'b0;
    rdDat  = 'x;
    @(posedge wbClk);
    #1;
    wbAdr     = adr;
    wbWe      = we;
    wbByteStb = stb;
    wbWrDat   = wrDat;
    wbCyc     = 1'b1;
    wbStb     = 1'b1;
    // Outputs sampled mid-cycle where they are stable
    while (!gotAck && waited < ACK_LIMIT)
    begin
        @(negedge wbClk);
        if (wbAck)
        begin
            gotAck = 1'b1;
            rdDat  = wbRdDat;
        end
        else
            waited++;
    end
    if (!gotAck)
    begin
        $display("No acknowledge arrived for the access to address %05h", adr);
        ackErrors++;
    end
    @(posedge wbClk);
    #1;
    wbCyc   = 1'b0;
    wbStb   = 1'b0;
    wbWe    = 1'b0;
    latency = waited;
endtask

task automatic checkValue(input string name, input busData_t expected, input busData_t actual);
    assert (actual === expected)
    else
    begin
        $display("Fail %s: expected %08h, actual %08h", name, expected, actual);
        valueErrors++;
    end
endtask

task automatic readCheck(input string name, input logic [BUS_ADR_W-1:0] adr,
                         input busData_t expected);
    busData_t rd;
    int       lat;
    busAccess(adr, 1'b0, 4'hF, '0, rd, lat);
    checkValue(name, expected, rd);
endtask

`endif

//--- bench/fabricTb.sv
// Testbench for the fabric bus target
// Drives host transfers into every aperture and checks read data,
// GPIO outputs and the ack protocol

`timescale 1ns/1ps

module fabricTb
    import fabricPkg::*;
();
    // Worst case is about 55 transfers of at most 18 cycles each
    localparam int MAX_CYCLES = 2000;
    localparam int ACK_LIMIT  = 16;

    logic                 wbClk;
    logic                 arstN;
    logic [BUS_ADR_W-1:0] wbAdr;
    logic                 wbCyc;
    logic                 wbStb;
    logic                 wbWe;
    byteStb_t             wbByteStb;
    busData_t             wbWrDat;
    busData_t             wbRdDat;
    logic                 wbAck;
    gpio_t                gpioIn;
    gpio_t                gpioOut;
    gpio_t                gpioOe;
    busData_t             deviceId;

    int valueErrors = 0;
    int ackErrors   = 0;
    int protoErrors = 0;
    int cycleCount  = 0;

    `include "wbHostTasks.svh"

    fabricTop fabricTop_i
    (
        .wbClk_i     (wbClk),
        .arstN_i     (arstN),
        .wbAdr_i     (wbAdr),
        .wbCyc_i     (wbCyc),
        .wbStb_i     (wbStb),
        .wbWe_i      (wbWe),
        .wbByteStb_i (wbByteStb),
        .wbWrDat_i   (wbWrDat),
        .wbRdDat_o   (wbRdDat),
        .wbAck_o     (wbAck),
        .gpioIn_i    (gpioIn),
        .gpioOut_o   (gpioOut),
        .gpioOe_o    (gpioOe),
        .deviceId_o  (deviceId)
    );

    initial
    begin
        wbClk = 1'b0;
        forever #4 wbClk = ~wbClk;
    end

    // ------------------------------------------------------------
    // Bus protocol checks
    // ------------------------------------------------------------
    ackSinglePulse: assert property (@(posedge wbClk) disable iff (!arstN) wbAck |=> !wbAck)
    else
    begin
        $display("Acknowledge stayed high for two cycles");
        protoErrors++;
    end

    ackNeedsStrobe: assert property (@(posedge wbClk) disable iff (!arstN)
                                     $rose(wbAck) |-> (wbCyc && wbStb))
    else
    begin
        $display("Acknowledge rose without cyc and stb");
        protoErrors++;
    end

    // Watchdog
    always @(posedge wbClk)
    begin
        cycleCount++;
        if (cycleCount >= MAX_CYCLES)
        begin
            $display("Run stopped after %0d cycles without finishing", cycleCount);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial
    begin
        busData_t rd;
        busData_t data;
        gpio_t    outVal;
        gpio_t    oeVal;
        int       lat;
        int       apers[6];
        void'($urandom(65822));
        apers = '{1, 2, 3, 4, 5, 7};
        arstN = 1'b0;
        wbAdr = '0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbByteStb = '0;
        wbWrDat = '0;
        gpioIn = '0;
        repeat (16) @(posedge wbClk);
        #1 arstN = 1'b1;

        // Reset state and identification
        checkValue("gpioOutReset", '0, busData_t'(gpioOut));
        checkValue("gpioOeReset", '0, busData_t'(gpioOe));
        checkValue("deviceIdPort", {16'h0000, DEVICE_ID}, deviceId);
        readCheck("idRead", byteAddress(APER_REGS, REG_ID_IDX), {16'h0000, DEVICE_ID});
        readCheck("revRead", byteAddress(APER_REGS, REG_REV_IDX), REV_LEVEL);

        // GPIO output and enable writes, then masked writes
        repeat (4)
        begin
            data = $urandom;
            outVal = data[7:0];
            busAccess(byteAddress(APER_REGS, REG_GPIO_OUT_IDX), 1'b1, 4'h1, data, rd, lat);
            data = $urandom;
            oeVal = data[7:0];
            busAccess(byteAddress(APER_REGS, REG_GPIO_OE_IDX), 1'b1, 4'hF, data, rd, lat);
            checkValue("gpioOutPort", busData_t'(outVal), busData_t'(gpioOut));
            checkValue("gpioOePort", busData_t'(oeVal), busData_t'(gpioOe));
            readCheck("gpioOutRead", byteAddress(APER_REGS, REG_GPIO_OUT_IDX), busData_t'(outVal));
            readCheck("gpioOeRead", byteAddress(APER_REGS, REG_GPIO_OE_IDX), busData_t'(oeVal));
            busAccess(byteAddress(APER_REGS, REG_GPIO_OUT_IDX), 1'b1, 4'hE,
                      busData_t'(~outVal), rd, lat);
            busAccess(byteAddress(APER_REGS, REG_GPIO_OE_IDX), 1'b1, 4'hE, ~data, rd, lat);
            checkValue("gpioOutMasked", busData_t'(outVal), busData_t'(gpioOut));
            checkValue("gpioOeMasked", busData_t'(oeVal), busData_t'(gpioOe));
        end

        // GPIO input sampling
        repeat (4)
        begin
            gpioIn = gpio_t'($urandom);
            readCheck("gpioInRead", byteAddress(APER_REGS, REG_GPIO_IN_IDX), busData_t'(gpioIn));
        end

        // Identification block and undefined indices
        readCheck("custProd", byteAddress(APER_RESERVED, RSV_CUST_PROD_IDX), 32'h0000_0100);
        readCheck("revisions", byteAddress(APER_RESERVED, RSV_REVISIONS_IDX), 32'h0001_0000);
        readCheck("rsvUndef", byteAddress(APER_RESERVED, 7'h10), RSV_UNDEF_VALUE);
        readCheck("regUndef", byteAddress(APER_REGS, 7'h05), REG_UNDEF_VALUE);

        // Each unmapped aperture followed by a register access
        foreach (apers[i])
        begin
            busAccess(byteAddress(apers[i], 7'h03), 1'b1, 4'hF, $urandom, rd, lat);
            readCheck("badAccess", byteAddress(apers[i], 7'h03), BAD_ACCESS_VALUE);
            busAccess(byteAddress(APER_REGS, REG_ID_IDX), 1'b0, 4'hF, '0, rd, lat);
            checkValue("idAfterBad", {16'h0000, DEVICE_ID}, rd);
            checkValue("ackLatency", 32'd1, busData_t'(lat));
        end

        repeat (4) @(posedge wbClk);
        $display("Errors: value %0d, acknowledge %0d, protocol %0d",
                 valueErrors, ackErrors, protoErrors);
        if (valueErrors + ackErrors + protoErrors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- logic/accessTimeout.sv
// Timeout responder for unmapped apertures
// Counts the cycles of a selected access and answers it after a
// fixed wait with a marker read value, so the host never hangs

`timescale 1ns/1ps

module accessTimeout
    import fabricPkg::*;
(
    input  logic      wbClk_i,
    input  logic      arstN_i,
    wbTargetIf.target bus
);

    logic [TIMEOUT_CNT_W-1:0] waitCnt;
    logic                     fired;
    logic                     ackQ;
    logic                     expired;

    assign expired = (waitCnt == TIMEOUT_CNT_W'(TIMEOUT_CYCLES));

    // ------------------------------------------------------------
    // Wait counter and ack pulse
    // ------------------------------------------------------------
    always_ff @(posedge wbClk_i or negedge arstN_i)
    begin
        if (!arstN_i)
        begin
            waitCnt <= '0;
            fired   <= 1'b0;
            ackQ    <= 1'b0;
        end
        else if (!bus.sel)
        begin
            // Access gone, ready for the next one
            waitCnt <= '0;
            fired   <= 1'b0;
            ackQ    <= 1'b0;
        end
        else
        begin
            ackQ <= 1'b0;
            if (!fired)
            begin
                if (expired)
                begin
                    ackQ  <= 1'b1;
                    fired <= 1'b1;
                end
                else
                    waitCnt <= waitCnt + 1'b1;
            end
        end
    end

    assign bus.rdDat = BAD_ACCESS_VALUE;
    assign bus.ack   = ackQ;

endmodule

//--- logic/fabricPkg.sv
// Fabric bus target package
// Bus widths, aperture map, register word indices, identification
// constants and the marker values returned on undefined accesses

package fabricPkg;

    // ------------------------------------------------------------
    // Bus geometry
    // ------------------------------------------------------------
    localparam int BUS_ADR_W  = 17;
    localparam int BUS_DAT_W  = 32;
    localparam int BYTE_LANES = 4;
    localparam int GPIO_W     = 8;

    // Aperture field is address bits 16..13, word index is bits 8..2
    localparam int APER_LSB   = 13;
    localparam int APER_W     = BUS_ADR_W - APER_LSB;
    localparam int REG_IDX_W  = 7;

    typedef logic [BUS_DAT_W-1:0]  busData_t;
    typedef logic [REG_IDX_W-1:0]  regIdx_t;
    typedef logic [BYTE_LANES-1:0] byteStb_t;
    typedef logic [GPIO_W-1:0]     gpio_t;
    typedef logic [APER_W-1:0]     aperture_t;

    // ------------------------------------------------------------
    // Aperture map
    // ------------------------------------------------------------
    // Register block at 0x00000, reserved block at 0x0C000
    localparam aperture_t APER_REGS     = 4'd0;
    localparam aperture_t APER_RESERVED = 4'd6;

    // Register block word indices
    localparam regIdx_t REG_ID_IDX       = 7'h00;
    localparam regIdx_t REG_REV_IDX      = 7'h01;
    localparam regIdx_t REG_GPIO_IN_IDX  = 7'h02;
    localparam regIdx_t REG_GPIO_OUT_IDX = 7'h03;
    localparam regIdx_t REG_GPIO_OE_IDX  = 7'h04;

    // Reserved block word indices, top of the aperture
    localparam regIdx_t RSV_CUST_PROD_IDX = 7'h7E;
    localparam regIdx_t RSV_REVISIONS_IDX = 7'h7F;

    // ------------------------------------------------------------
    // Identification and marker values
    // ------------------------------------------------------------
    localparam logic [15:0] DEVICE_ID   = 16'hA10F;
    localparam busData_t    REV_LEVEL   = 32'h0000_0100;
    localparam logic [7:0]  CUSTOMER_ID = 8'h01;
    localparam logic [7:0]  PRODUCT_ID  = 8'h00;
    localparam logic [15:0] MAJOR_REV   = 16'h0001;
    localparam logic [15:0] MINOR_REV   = 16'h0000;

    localparam busData_t REG_UNDEF_VALUE  = 32'hFABD_EFAC;
    localparam busData_t RSV_UNDEF_VALUE  = 32'hDEFF_ABAC;
    localparam busData_t BAD_ACCESS_VALUE = 32'hBADF_ABAC;

    // Unmapped access responder
    localparam int TIMEOUT_CNT_W  = 3;
    localparam int TIMEOUT_CYCLES = 7;

endpackage

//--- logic/fabricRegisters.sv
// General fabric register block
// Device ID and revision words, GPIO input sampling and the GPIO
// output and output-enable registers. Every access is answered one
// edge after select with a single-cycle ack

`timescale 1ns/1ps

module fabricRegisters
    import fabricPkg::*;
(
    input  logic      wbClk_i,
    input  logic      arstN_i,
    wbTargetIf.target bus,

    input  gpio_t     gpioIn_i,
    output gpio_t     gpioOut_o,
    output gpio_t     gpioOe_o,
    output busData_t  deviceId_o
);

    logic     served;
    logic     ackQ;
    logic     firstBeat;
    logic     wrLow;
    gpio_t    gpioOutQ;
    gpio_t    gpioOeQ;
    busData_t idWord;

    assign idWord    = busData_t'(DEVICE_ID);
    assign firstBeat = bus.sel & ~served;

    // Only the low byte lane carries the GPIO bits
    assign wrLow = firstBeat & bus.we & bus.byteStb[0];

    // ------------------------------------------------------------
    // Acknowledge
    // ------------------------------------------------------------
    // served keeps ack from firing twice within one held strobe
    always_ff @(posedge wbClk_i or negedge arstN_i)
    begin
        if (!arstN_i)
        begin
            served <= 1'b0;
            ackQ   <= 1'b0;
        end
        else
        begin
            served <= bus.sel;
            ackQ   <= firstBeat;
        end
    end

    // ------------------------------------------------------------
    // GPIO output registers
    // ------------------------------------------------------------
    always_ff @(posedge wbClk_i or negedge arstN_i)
    begin
        if (!arstN_i)
        begin
            gpioOutQ <= '0;
            gpioOeQ  <= '0;
        end
        else if (wrLow)
        begin
            if (bus.idx == REG_GPIO_OUT_IDX)
                gpioOutQ <= bus.wrDat[GPIO_W-1:0];
            if (bus.idx == REG_GPIO_OE_IDX)
                gpioOeQ <= bus.wrDat[GPIO_W-1:0];
        end
    end

    // Read mux, index is held stable by the host during the cycle
    always_comb
    begin
        case (bus.idx)
            REG_ID_IDX:       bus.rdDat = idWord;
            REG_REV_IDX:      bus.rdDat = REV_LEVEL;
            REG_GPIO_IN_IDX:  bus.rdDat = busData_t'(gpioIn_i);
            REG_GPIO_OUT_IDX: bus.rdDat = busData_t'(gpioOutQ);
            REG_GPIO_OE_IDX:  bus.rdDat = busData_t'(gpioOeQ);
            default:          bus.rdDat = REG_UNDEF_VALUE;
        endcase
    end

    assign bus.ack    = ackQ;
    assign gpioOut_o  = gpioOutQ;
    assign gpioOe_o   = gpioOeQ;
    assign deviceId_o = idWord;

endmodule

//--- logic/fabricTop.sv
// Fabric-side bus target top level
// Host slave port, aperture router, general register block,
// reserved identification block and the unmapped-access responder

`timescale 1ns/1ps

module fabricTop
    import fabricPkg::*;
(
    input  logic                 wbClk_i,
    input  logic                 arstN_i,

    // Host bus
    input  logic [BUS_ADR_W-1:0] wbAdr_i,
    input  logic                 wbCyc_i,
    input  logic                 wbStb_i,
    input  logic                 wbWe_i,
    input  byteStb_t             wbByteStb_i,
    input  busData_t             wbWrDat_i,
    output busData_t             wbRdDat_o,
    output logic                 wbAck_o,

    // GPIO and identification
    input  gpio_t                gpioIn_i,
    output gpio_t                gpioOut_o,
    output gpio_t                gpioOe_o,
    output busData_t             deviceId_o
);

    wbTargetIf regBus ();
    wbTargetIf rsvBus ();
    wbTargetIf dfltBus ();

    // ------------------------------------------------------------
    // Decode and return
    // ------------------------------------------------------------
    wbApertureRouter router_i
    (
        .wbAdr_i     (wbAdr_i),
        .wbCyc_i     (wbCyc_i),
        .wbStb_i     (wbStb_i),
        .wbWe_i      (wbWe_i),
        .wbByteStb_i (wbByteStb_i),
        .wbWrDat_i   (wbWrDat_i),
        .wbRdDat_o   (wbRdDat_o),
        .wbAck_o     (wbAck_o),
        .regBus      (regBus),
        .rsvBus      (rsvBus),
        .dfltBus     (dfltBus)
    );

    // ------------------------------------------------------------
    // Targets
    // ------------------------------------------------------------
    fabricRegisters registers_i
    (
        .wbClk_i    (wbClk_i),
        .arstN_i    (arstN_i),
        .bus        (regBus),
        .gpioIn_i   (gpioIn_i),
        .gpioOut_o  (gpioOut_o),
        .gpioOe_o   (gpioOe_o),
        .deviceId_o (deviceId_o)
    );

    reservedIdRegs reserved_i
    (
        .wbClk_i (wbClk_i),
        .arstN_i (arstN_i),
        .bus     (rsvBus)
    );

    // Catches every aperture not claimed above
    accessTimeout timeout_i
    (
        .wbClk_i (wbClk_i),
        .arstN_i (arstN_i),
        .bus     (dfltBus)
    );

endmodule

//--- logic/reservedIdRegs.sv
// Reserved identification block
// Read-only customer/product and major/minor revision words.
// Writes are acknowledged and dropped

`timescale 1ns/1ps

module reservedIdRegs
    import fabricPkg::*;
(
    input  logic      wbClk_i,
    input  logic      arstN_i,
    wbTargetIf.target bus
);

    logic served;
    logic ackQ;

    // Single ack per select, same timing as the register block
    always_ff @(posedge wbClk_i or negedge arstN_i)
    begin
        if (!arstN_i)
        begin
            served <= 1'b0;
            ackQ   <= 1'b0;
        end
        else
        begin
            served <= bus.sel;
            ackQ   <= bus.sel & ~served;
        end
    end

    // ID words sit at the top two indices of the aperture
    always_comb
    begin
        case (bus.idx)
            RSV_CUST_PROD_IDX: bus.rdDat = busData_t'({CUSTOMER_ID, PRODUCT_ID});
            RSV_REVISIONS_IDX: bus.rdDat = {MAJOR_REV, MINOR_REV};
            default:           bus.rdDat = RSV_UNDEF_VALUE;
        endcase
    end

    assign bus.ack = ackQ;

endmodule

//--- logic/wbApertureRouter.sv
// Aperture router for the host bus slave port
// Decodes the aperture field of the byte address, raises the select
// of one target and merges read data and ack back to the host.
// Anything outside the register and reserved apertures goes to
// the default (timeout) target

`timescale 1ns/1ps

module wbApertureRouter
    import fabricPkg::*;
(
    // Host side
    input  logic [BUS_ADR_W-1:0] wbAdr_i,
    input  logic                 wbCyc_i,
    input  logic                 wbStb_i,
    input  logic                 wbWe_i,
    input  byteStb_t             wbByteStb_i,
    input  busData_t             wbWrDat_i,
    output busData_t             wbRdDat_o,
    output logic                 wbAck_o,

    // Target side
    wbTargetIf.router            regBus,
    wbTargetIf.router            rsvBus,
    wbTargetIf.router            dfltBus
);

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------
    aperture_t aper;
    regIdx_t   wordIdx;
    logic      access;
    logic      hitRegs;
    logic      hitRsv;

    assign aper    = wbAdr_i[BUS_ADR_W-1:APER_LSB];
    assign wordIdx = wbAdr_i[REG_IDX_W+1:2];
    assign access  = wbCyc_i & wbStb_i;

    assign hitRegs = (aper == APER_REGS);
    assign hitRsv  = (aper == APER_RESERVED);

    // One select at a time, default catches the rest
    assign regBus.sel  = access & hitRegs;
    assign rsvBus.sel  = access & hitRsv;
    assign dfltBus.sel = access & ~hitRegs & ~hitRsv;

    // ------------------------------------------------------------
    // Forward the transfer fields to every target
    // ------------------------------------------------------------
    assign regBus.idx      = wordIdx;
    assign regBus.we       = wbWe_i;
    assign regBus.byteStb  = wbByteStb_i;
    assign regBus.wrDat    = wbWrDat_i;

    assign rsvBus.idx      = wordIdx;
    assign rsvBus.we       = wbWe_i;
    assign rsvBus.byteStb  = wbByteStb_i;
    assign rsvBus.wrDat    = wbWrDat_i;

    assign dfltBus.idx     = wordIdx;
    assign dfltBus.we      = wbWe_i;
    assign dfltBus.byteStb = wbByteStb_i;
    assign dfltBus.wrDat   = wbWrDat_i;

    // ------------------------------------------------------------
    // Return path
    // ------------------------------------------------------------
    // Purely combinational, the targets register their own ack
    always_comb
    begin
        if (hitRegs)
        begin
            wbRdDat_o = regBus.rdDat;
            wbAck_o   = regBus.ack;
        end
        else if (hitRsv)
        begin
            wbRdDat_o = rsvBus.rdDat;
            wbAck_o   = rsvBus.ack;
        end
        else
        begin
            wbRdDat_o = dfltBus.rdDat;
            wbAck_o   = dfltBus.ack;
        end
    end

endmodule

//--- logic/wbTargetIf.sv
// Routed transfer between the aperture router and one bus target
// Router drives select, index and write fields; the target answers
// with read data and a one-cycle acknowledge

`timescale 1ns/1ps

interface wbTargetIf
    import fabricPkg::*;
();
    logic     sel;
    regIdx_t  idx;
    logic     we;
    byteStb_t byteStb;
    busData_t wrDat;
    busData_t rdDat;
    logic     ack;

    modport router
    (
        output sel, idx, we, byteStb, wrDat,
        input  rdDat, ack
    );

    modport target
    (
        input  sel, idx, we, byteStb, wrDat,
        output rdDat, ack
    );

endinterface

//--- verilog.f
+incdir+bench
logic/fabricPkg.sv
logic/wbTargetIf.sv
logic/wbApertureRouter.sv
logic/fabricRegisters.sv
logic/reservedIdRegs.sv
logic/accessTimeout.sv
logic/fabricTop.sv
bench/fabricTb.sv
